// File: project.f
lstm_pkg.sv
act_tanh.sv
act_sigmoid.sv
lstm_cell_update.sv
lstm_csr.sv
lstm_cell_top.sv
tb_clk_gen.sv
tb_lstm_cell.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert -Wno-fatal
TOP       := tb_lstm_cell
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_TEXT := TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_lstm_cell.sv
`timescale 1ns/1ps

module tb_lstm_cell;

  localparam int DEPTH      = 8;  // small array, frequent index collisions
  localparam int IDX_W      = $clog2(DEPTH);
  localparam int NUM_RANDOM = 200;
  localparam int MAX_CYCLES = 5000;  // ~300 items at worst-case stall plus register traffic

  logic                                  clk;
  logic                                  arst_n;
  logic [lstm_pkg::AXI_ADDR_WIDTH-1:0]   s_axil_awaddr;
  logic                                  s_axil_awvalid;
  logic                                  s_axil_awready;
  logic [lstm_pkg::AXI_DATA_WIDTH-1:0]   s_axil_wdata;
  logic [lstm_pkg::AXI_DATA_WIDTH/8-1:0] s_axil_wstrb;
  logic                                  s_axil_wvalid;
  logic                                  s_axil_wready;
  logic [1:0]                            s_axil_bresp;
  logic                                  s_axil_bvalid;
  logic                                  s_axil_bready;
  logic [lstm_pkg::AXI_ADDR_WIDTH-1:0]   s_axil_araddr;
  logic                                  s_axil_arvalid;
  logic                                  s_axil_arready;
  logic [lstm_pkg::AXI_DATA_WIDTH-1:0]   s_axil_rdata;
  logic [1:0]                            s_axil_rresp;
  logic                                  s_axil_rvalid;
  logic                                  s_axil_rready;
  logic                                  in_valid;
  logic                                  in_ready;
  logic [IDX_W-1:0]                      in_idx;
  logic [15:0]                           in_gate_i;
  logic [15:0]                           in_gate_f;
  logic [15:0]                           in_gate_g;
  logic [15:0]                           in_gate_o;
  logic                                  out_valid;
  logic                                  out_ready;
  logic [IDX_W-1:0]                      out_idx;
  logic [15:0]                           out_h;
  logic [15:0]                           out_c;

  integer           seed = 13;
  string            test_name = "reset";
  int               cycle_count = 0;
  int               out_count = 0;
  int               error_count = 0;
  bit               random_ready = 1'b0;
  bit               ready_draw = 1'b1;
  int               model_state [DEPTH];
  logic [15:0]      corner_vals [10];
  logic [IDX_W-1:0] exp_idx_q [$];
  logic [15:0]      exp_h_q [$];
  logic [15:0]      exp_c_q [$];

  tb_clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

  lstm_cell_top #(.ARRAY_DEPTH(DEPTH)) dut
  (
    .clk            (clk),
    .arst_n         (arst_n),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_idx         (in_idx),
    .in_gate_i      (in_gate_i),
    .in_gate_f      (in_gate_f),
    .in_gate_g      (in_gate_g),
    .in_gate_o      (in_gate_o),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_idx        (out_idx),
    .out_h          (out_h),
    .out_c          (out_c)
  );

  // tanh at the center of each 0.1 bin from 0.5, last bin holds tanh(3.0)
  function automatic int tanh_bin_value(input int bin);
    case (bin)
      0:       return 'h0802;
      1:       return 'h0925;
      2:       return 'h0a29;
      3:       return 'h0b0e;
      4:       return 'h0bd6;
      5:       return 'h0c82;
      6:       return 'h0d15;
      7:       return 'h0d92;
      8:       return 'h0dfc;
      9:       return 'h0e54;
      10:      return 'h0e9e;
      11:      return 'h0edc;
      12:      return 'h0f0f;
      13:      return 'h0f3a;
      14:      return 'h0f5d;
      15:      return 'h0f7a;
      16:      return 'h0f92;
      17:      return 'h0fa6;
      18:      return 'h0fb6;
      19:      return 'h0fc3;
      20:      return 'h0fce;
      default: return 'h0feb;
    endcase
  endfunction

  // t tenths in Q4.12, fraction rounded to nearest lsb
  function automatic int bin_bound(input int t);
    return (t / 10) * 4096 + ((t % 10) * 4096 + 5) / 10;
  endfunction

  function automatic int ref_tanh(input int x);
    int mag;
    int val;
    int bin;
    mag = (x < 0) ? -x : x;
    if (mag < 2048)
      val = mag;
    else if (mag >= 12288)
      val = 4096;
    else
    begin
      bin = 0;
      for (int t = 6; t <= 26; t++)
      begin
        if (mag >= bin_bound(t))
          bin++;
      end
      val = tanh_bin_value(bin);
    end
    return (x < 0) ? -val : val;
  endfunction

  function automatic int ref_sigmoid(input int x);
    return (ref_tanh(x >>> 1) >>> 1) + 2048;
  endfunction

  // one element through the model, updates the stored cell state
  function automatic void ref_step(input int idx, input logic [15:0] gi, input logic [15:0] gf,
                                   input logic [15:0] gg, input logic [15:0] go,
                                   output logic [15:0] h, output logic [15:0] c);
    int si;
    int sf;
    int tg;
    int so;
    int c_new;
    int hv;
    si = ref_sigmoid(int'($signed(gi)));
    sf = ref_sigmoid(int'($signed(gf)));
    tg = ref_tanh(int'($signed(gg)));
    so = ref_sigmoid(int'($signed(go)));
    c_new = ((sf * model_state[idx]) >>> 12) + ((si * tg) >>> 12);
    if (c_new > 32767)
      c_new = 32767;
    else if (c_new < -32768)
      c_new = -32768;
    model_state[idx] = c_new;
    hv = (so * ref_tanh(c_new)) >>> 12;
    h = hv[15:0];
    c = c_new[15:0];
  endfunction

  function automatic logic [15:0] random_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
      abort_run($sformatf("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                          test_name, what, expected, actual));
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wstrb   = 4'hf;
    s_axil_wvalid  = 1'b1;
    @(negedge clk);
    while (!s_axil_awready) @(negedge clk);
    check_equal("wready", 32'd1, 32'(s_axil_wready));
    @(posedge clk);
    #1;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    @(negedge clk);
    while (!s_axil_bvalid) @(negedge clk);
    @(posedge clk);  // response must hold while bready is low
    #1;
    check_equal("bvalid held", 32'd1, 32'(s_axil_bvalid));
    check_equal("bresp", 32'd0, 32'(s_axil_bresp));
    s_axil_bready = 1'b1;
    @(posedge clk);
    #1;
    s_axil_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    @(negedge clk);
    while (!s_axil_arready) @(negedge clk);
    @(posedge clk);
    #1;
    s_axil_arvalid = 1'b0;
    @(negedge clk);
    while (!s_axil_rvalid) @(negedge clk);
    @(posedge clk);  // response must hold while rready is low
    #1;
    data = s_axil_rdata;
    check_equal("rvalid held", 32'd1, 32'(s_axil_rvalid));
    check_equal("rresp", 32'd0, 32'(s_axil_rresp));
    s_axil_rready = 1'b1;
    @(posedge clk);
    #1;
    s_axil_rready = 1'b0;
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] value;
    axi_read(addr, value);
    check_equal(what, expected, value);
  endtask

  // holds the item until accepted, expected result queued at acceptance
  task automatic send_item(input int idx, input logic [15:0] gi, input logic [15:0] gf,
                           input logic [15:0] gg, input logic [15:0] go);
    logic [15:0] h;
    logic [15:0] c;
    in_valid  = 1'b1;
    in_idx    = idx[IDX_W-1:0];
    in_gate_i = gi;
    in_gate_f = gf;
    in_gate_g = gg;
    in_gate_o = go;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    ref_step(idx, gi, gf, gg, go, h, c);
    exp_idx_q.push_back(idx[IDX_W-1:0]);
    exp_h_q.push_back(h);
    exp_c_q.push_back(c);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_idx_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // output side back-pressure, drawn at the edge and driven 1 ns later
  always @(posedge clk)
  begin
    if (random_ready)
      ready_draw = (($random(seed) & 3) != 0);
    else
      ready_draw = 1'b1;
    #1;
    out_ready = ready_draw;
  end

  // compare at mid-cycle, transfer happens on the next rising edge
  always @(negedge clk)
  begin
    if (arst_n && out_valid && out_ready)
    begin
      if (exp_idx_q.size() == 0)
        abort_run("An output transfer arrived while no input was waiting for one");
      else
      begin
        check_equal("out_idx", 32'(exp_idx_q.pop_front()), 32'(out_idx));
        check_equal("out_h", 32'(exp_h_q.pop_front()), 32'(out_h));
        check_equal("out_c", 32'(exp_c_q.pop_front()), 32'(out_c));
        out_count++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
      abort_run($sformatf("Timeout: test %s did not finish within %0d cycles",
                          test_name, MAX_CYCLES));
  end

  initial
  begin
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    in_valid       = 1'b0;
    in_idx         = '0;
    in_gate_i      = '0;
    in_gate_f      = '0;
    in_gate_g      = '0;
    in_gate_o      = '0;
    out_ready      = 1'b1;
    foreach (model_state[n])
      model_state[n] = 0;
    // 0, +-0.3, +-1.0, +-2.2, +-5.0, most negative
    corner_vals = '{16'h0000, 16'h04cd, 16'hfb33, 16'h1000, 16'hf000,
                    16'h2333, 16'hdccd, 16'h5000, 16'hb000, 16'h8000};
    wait (arst_n);
    @(posedge clk);
    #1;

    read_check(lstm_pkg::REG_CTRL, 32'd0, "CTRL");
    read_check(lstm_pkg::REG_STATUS, 32'd0, "STATUS");
    read_check(lstm_pkg::REG_STATE_DATA, 32'd0, "STATE_DATA");
    in_valid = 1'b1;
    in_idx   = 3'd2;
    repeat (5)
    begin
      @(negedge clk);
      check_equal("in_ready while disabled", 32'd0, 32'(in_ready));
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;

    axi_write(lstm_pkg::REG_CTRL, 32'd1);
    test_name = "corner";
    for (int n = 0; n < 10; n++)
    begin
      send_item(n % DEPTH, corner_vals[n], corner_vals[n], corner_vals[n], corner_vals[n]);
      wait_drain();
      send_item(n % DEPTH, corner_vals[n], corner_vals[(n + 3) % 10],
                corner_vals[(n + 5) % 10], corner_vals[(n + 7) % 10]);
      wait_drain();
    end

    test_name = "accumulate";
    for (int n = 0; n < 14; n++)
      send_item(3, 16'h5000, 16'h5000, 16'h5000, 16'h1000);  // climbs to +8.0
    for (int n = 0; n < 24; n++)
      send_item(3, 16'h5000, 16'h5000, 16'hb000, 16'h1000);  // falls to -8.0
    wait_drain();
    axi_write(lstm_pkg::REG_STATE_SEL, 32'd3);
    read_check(lstm_pkg::REG_STATE_DATA, 32'hffff8000, "saturated state");

    test_name = "random";
    random_ready = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++)
      send_item(random_word() % DEPTH, random_word(), random_word(), random_word(),
                random_word());
    wait_drain();
    random_ready = 1'b0;
    read_check(lstm_pkg::REG_STATUS, 32'(out_count), "STATUS count");

    test_name = "readback";
    for (int n = 0; n < DEPTH; n++)
    begin
      axi_write(lstm_pkg::REG_STATE_SEL, 32'(n));
      read_check(lstm_pkg::REG_STATE_DATA, 32'(model_state[n]), "STATE_DATA");
    end

    test_name = "clear";
    axi_write(lstm_pkg::REG_CTRL, 32'd3);  // enable plus clear pulse
    foreach (model_state[n])
      model_state[n] = 0;
    read_check(lstm_pkg::REG_CTRL, 32'd1, "CTRL after clear");
    for (int n = 0; n < DEPTH; n++)
    begin
      axi_write(lstm_pkg::REG_STATE_SEL, 32'(n));
      read_check(lstm_pkg::REG_STATE_DATA, 32'd0, "STATE_DATA after clear");
    end
    send_item(5, 16'h1000, 16'h2333, 16'h1000, 16'h04cd);
    send_item(5, 16'h5000, 16'h1000, 16'hf000, 16'h1000);
    wait_drain();
    axi_write(lstm_pkg::REG_STATE_SEL, 32'd5);
    read_check(lstm_pkg::REG_STATE_DATA, 32'(model_state[5]), "STATE_DATA after restart");

    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
#(
  parameter int HALF_PERIOD  = 5,  // 10 ns clock
  parameter int RESET_CYCLES = 3
)
(
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;  // release away from the edge
  end

endmodule

// File: lstm_cell_top.sv
`timescale 1ns/1ps

module lstm_cell_top
#(
  parameter int ARRAY_DEPTH = lstm_pkg::DEFAULT_ARRAY_DEPTH
)
(
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [lstm_pkg::AXI_ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                                  s_axil_awvalid,
  output logic                                  s_axil_awready,
  input  logic [lstm_pkg::AXI_DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic [lstm_pkg::AXI_DATA_WIDTH/8-1:0] s_axil_wstrb,
  input  logic                                  s_axil_wvalid,
  output logic                                  s_axil_wready,
  output logic [1:0]                            s_axil_bresp,
  output logic                                  s_axil_bvalid,
  input  logic                                  s_axil_bready,
  input  logic [lstm_pkg::AXI_ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                                  s_axil_arvalid,
  output logic                                  s_axil_arready,
  output logic [lstm_pkg::AXI_DATA_WIDTH-1:0]   s_axil_rdata,
  output logic [1:0]                            s_axil_rresp,
  output logic                                  s_axil_rvalid,
  input  logic                                  s_axil_rready,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  input  logic [$clog2(ARRAY_DEPTH)-1:0]        in_idx,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]       in_gate_i,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]       in_gate_f,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]       in_gate_g,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]       in_gate_o,
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output logic [$clog2(ARRAY_DEPTH)-1:0]        out_idx,
  output logic [lstm_pkg::DATA_WIDTH-1:0]       out_h,
  output logic [lstm_pkg::DATA_WIDTH-1:0]       out_c
);

  localparam int IDX_W = $clog2(ARRAY_DEPTH);

  logic                            enable;
  logic                            clear_state;
  logic [IDX_W-1:0]                state_sel;
  logic [lstm_pkg::DATA_WIDTH-1:0] state_rdata;
  logic                            elem_done;

  lstm_csr #(.ARRAY_DEPTH(ARRAY_DEPTH)) u_csr
  (
    .clk            (clk),
    .arst_n         (arst_n),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .enable         (enable),
    .clear_state    (clear_state),
    .state_sel      (state_sel),
    .state_rdata    (state_rdata),
    .elem_done      (elem_done)
  );

  lstm_cell_update #(.ARRAY_DEPTH(ARRAY_DEPTH)) u_cell
  (
    .clk         (clk),
    .arst_n      (arst_n),
    .enable      (enable),
    .clear_state (clear_state),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_idx      (in_idx),
    .in_gate_i   (in_gate_i),
    .in_gate_f   (in_gate_f),
    .in_gate_g   (in_gate_g),
    .in_gate_o   (in_gate_o),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_idx     (out_idx),
    .out_h       (out_h),
    .out_c       (out_c),
    .state_sel   (state_sel),
    .state_rdata (state_rdata),
    .elem_done   (elem_done)
  );

endmodule

// File: lstm_csr.sv
`timescale 1ns/1ps

module lstm_csr
#(
  parameter int ARRAY_DEPTH = lstm_pkg::DEFAULT_ARRAY_DEPTH
)
(
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [lstm_pkg::AXI_ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                                  s_axil_awvalid,
  output logic                                  s_axil_awready,
  input  logic [lstm_pkg::AXI_DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic [lstm_pkg::AXI_DATA_WIDTH/8-1:0] s_axil_wstrb,
  input  logic                                  s_axil_wvalid,
  output logic                                  s_axil_wready,
  output logic [1:0]                            s_axil_bresp,
  output logic                                  s_axil_bvalid,
  input  logic                                  s_axil_bready,
  input  logic [lstm_pkg::AXI_ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                                  s_axil_arvalid,
  output logic                                  s_axil_arready,
  output logic [lstm_pkg::AXI_DATA_WIDTH-1:0]   s_axil_rdata,
  output logic [1:0]                            s_axil_rresp,
  output logic                                  s_axil_rvalid,
  input  logic                                  s_axil_rready,
  output logic                                  enable,
  output logic                                  clear_state,
  output logic [$clog2(ARRAY_DEPTH)-1:0]        state_sel,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]       state_rdata,
  input  logic                                  elem_done
);

  localparam int AW    = lstm_pkg::AXI_ADDR_WIDTH;
  localparam int DW    = lstm_pkg::AXI_DATA_WIDTH;
  localparam int SW    = lstm_pkg::DATA_WIDTH;
  localparam int IDX_W = $clog2(ARRAY_DEPTH);

  logic          wr_accept, rd_accept;
  logic          wr_fire, rd_fire;
  logic [AW-1:0] wr_addr, rd_addr;
  logic [DW-1:0] wr_mask;
  logic [DW-1:0] sel_merged;
  logic [DW-1:0] rd_word;
  logic [DW-1:0] elem_count;

  assign s_axil_awready = wr_accept;  // aw and w taken together
  assign s_axil_wready  = wr_accept;
  assign s_axil_arready = rd_accept;
  assign s_axil_bresp   = 2'b00;      // always OKAY
  assign s_axil_rresp   = 2'b00;

  assign wr_fire = wr_accept && s_axil_awvalid && s_axil_wvalid;
  assign rd_fire = rd_accept && s_axil_arvalid;
  assign wr_addr = {s_axil_awaddr[AW-1:2], 2'b00};  // word aligned
  assign rd_addr = {s_axil_araddr[AW-1:2], 2'b00};

  always_comb
  begin
    for (int b = 0; b < DW / 8; b++)
      wr_mask[8*b +: 8] = {8{s_axil_wstrb[b]}};
  end

  assign sel_merged = ({{(DW-IDX_W){1'b0}}, state_sel} & ~wr_mask) | (s_axil_wdata & wr_mask);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_accept     <= 1'b0;
      s_axil_bvalid <= 1'b0;
      enable        <= 1'b0;
      clear_state   <= 1'b0;
      state_sel     <= '0;
    end
    else
    begin
      wr_accept   <= !wr_accept && !s_axil_bvalid && s_axil_awvalid && s_axil_wvalid;
      clear_state <= 1'b0;
      if (wr_fire)
        s_axil_bvalid <= 1'b1;
      else if (s_axil_bready)
        s_axil_bvalid <= 1'b0;
      if (wr_fire)
      begin
        case (wr_addr)
          lstm_pkg::REG_CTRL:
          begin
            if (s_axil_wstrb[0])
            begin
              enable      <= s_axil_wdata[0];
              clear_state <= s_axil_wdata[1];  // self-clearing pulse
            end
          end
          lstm_pkg::REG_STATE_SEL: state_sel <= sel_merged[IDX_W-1:0];
          default: ;  // status and state data are read only
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      elem_count <= '0;
    else
      elem_count <= elem_count + {{(DW-1){1'b0}}, elem_done};
  end

  always_comb
  begin
    case (rd_addr)
      lstm_pkg::REG_CTRL:       rd_word = {{(DW-1){1'b0}}, enable};
      lstm_pkg::REG_STATUS:     rd_word = elem_count;
      lstm_pkg::REG_STATE_SEL:  rd_word = {{(DW-IDX_W){1'b0}}, state_sel};
      lstm_pkg::REG_STATE_DATA: rd_word = {{(DW-SW){state_rdata[SW-1]}}, state_rdata};
      default:                  rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_accept     <= 1'b0;
      s_axil_rvalid <= 1'b0;
    end
    else
    begin
      rd_accept <= !rd_accept && !s_axil_rvalid && s_axil_arvalid;
      if (rd_fire)
        s_axil_rvalid <= 1'b1;
      else if (s_axil_rready)
        s_axil_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_fire)
      s_axil_rdata <= rd_word;  // captured at the address handshake
  end

  a_bresp_pending: assert property (@(posedge clk) disable iff (!arst_n)
    (s_axil_bvalid && !s_axil_bready) |=> (s_axil_bvalid && !s_axil_awready));

  a_rresp_pending: assert property (@(posedge clk) disable iff (!arst_n)
    (s_axil_rvalid && !s_axil_rready) |=> (s_axil_rvalid && !s_axil_arready
                                           && $stable(s_axil_rdata)));

endmodule

// File: lstm_cell_update.sv
`timescale 1ns/1ps

module lstm_cell_update
#(
  parameter int ARRAY_DEPTH = lstm_pkg::DEFAULT_ARRAY_DEPTH
)
(
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               enable,
  input  logic                               clear_state,
  input  logic                               in_valid,
  output logic                               in_ready,
  input  logic [$clog2(ARRAY_DEPTH)-1:0]     in_idx,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]    in_gate_i,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]    in_gate_f,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]    in_gate_g,
  input  logic [lstm_pkg::DATA_WIDTH-1:0]    in_gate_o,
  output logic                               out_valid,
  input  logic                               out_ready,
  output logic [$clog2(ARRAY_DEPTH)-1:0]     out_idx,
  output logic [lstm_pkg::DATA_WIDTH-1:0]    out_h,
  output logic [lstm_pkg::DATA_WIDTH-1:0]    out_c,
  input  logic [$clog2(ARRAY_DEPTH)-1:0]     state_sel,
  output logic [lstm_pkg::DATA_WIDTH-1:0]    state_rdata,
  output logic                               elem_done
);

  localparam int DW    = lstm_pkg::DATA_WIDTH;
  localparam int FB    = lstm_pkg::FRAC_BITS;
  localparam int IDX_W = $clog2(ARRAY_DEPTH);
  localparam int C_MAX = 2 ** (DW - 1) - 1;
  localparam int C_MIN = -(2 ** (DW - 1));

  logic              advance;
  logic              in_fire;
  logic [DW-1:0]     act_i, act_f, act_g, act_o;

  logic              s1_valid, s2_valid;
  logic [IDX_W-1:0]  s1_idx, s2_idx;
  logic signed [DW-1:0] s1_si, s1_sf, s1_tg, s1_so;
  logic signed [DW-1:0] s2_c, s2_so;

  logic signed [DW-1:0]   state_mem [ARRAY_DEPTH];
  logic signed [DW-1:0]   c_old;
  logic signed [2*DW-1:0] prod_f, prod_i;
  logic signed [2*DW:0]   c_sum;
  logic signed [DW-1:0]   c_new;

  logic [DW-1:0]          tanh_c;
  logic signed [2*DW-1:0] h_prod;
  logic signed [2*DW-1:0] h_shift;

  // single stall for the whole pipe
  assign advance   = !(out_valid && !out_ready);
  assign in_ready  = advance && enable;
  assign in_fire   = in_valid && in_ready;
  assign elem_done = out_valid && out_ready;

  // stage 1 activations
  act_sigmoid u_sig_i (.x(in_gate_i), .sig_out(act_i));
  act_sigmoid u_sig_f (.x(in_gate_f), .sig_out(act_f));
  act_tanh    u_tanh_g (.x(in_gate_g), .tanh_out(act_g));
  act_sigmoid u_sig_o (.x(in_gate_o), .sig_out(act_o));

  // stage 2, read-modify-write of the cell state in one cycle
  assign c_old  = state_mem[s1_idx];
  assign prod_f = s1_sf * c_old;
  assign prod_i = s1_si * s1_tg;
  assign c_sum  = (prod_f >>> FB) + (prod_i >>> FB);

  always_comb
  begin
    if (c_sum > C_MAX)
      c_new = 16'sh7fff;
    else if (c_sum < C_MIN)
      c_new = 16'sh8000;
    else
      c_new = c_sum[DW-1:0];
  end

  // stage 3 hidden output
  act_tanh u_tanh_c (.x(s2_c), .tanh_out(tanh_c));

  assign h_prod  = s2_so * $signed(tanh_c);
  assign h_shift = h_prod >>> FB;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int n = 0; n < ARRAY_DEPTH; n++)
        state_mem[n] <= '0;
    end
    else if (clear_state)
    begin
      for (int n = 0; n < ARRAY_DEPTH; n++)
        state_mem[n] <= '0;  // clear wins over a stage 2 write
    end
    else if (advance && s1_valid)
      state_mem[s1_idx] <= c_new;
  end

  assign state_rdata = state_mem[state_sel];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end
    else if (advance)
    begin
      s1_valid  <= in_fire;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (advance)
    begin
      s1_idx  <= in_idx;
      s1_si   <= act_i;
      s1_sf   <= act_f;
      s1_tg   <= act_g;
      s1_so   <= act_o;
      s2_idx  <= s1_idx;
      s2_c    <= c_new;
      s2_so   <= s1_so;
      out_idx <= s2_idx;
      out_c   <= s2_c;
      out_h   <= h_shift[DW-1:0];
    end
  end

  a_idx_range: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> (in_idx < ARRAY_DEPTH));

  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_h) && $stable(out_c)
                                   && $stable(out_idx)));

endmodule

// File: act_sigmoid.sv
`timescale 1ns/1ps

module act_sigmoid
(
  input  logic [lstm_pkg::DATA_WIDTH-1:0] x,
  output logic [lstm_pkg::DATA_WIDTH-1:0] sig_out
);

  localparam int DW = lstm_pkg::DATA_WIDTH;

  logic signed [DW-1:0] x_half;
  logic signed [DW-1:0] tanh_half;
  logic signed [DW-1:0] tanh_scaled;

  // sigmoid(x) = 0.5 + 0.5 * tanh(x / 2)
  assign x_half = $signed(x) >>> 1;

  act_tanh u_tanh
  (
    .x        (x_half),
    .tanh_out (tanh_half)
  );

  assign tanh_scaled = tanh_half >>> 1;  // floor, keeps -1.0 -> 0 exact
  assign sig_out     = tanh_scaled + lstm_pkg::FX_HALF;

endmodule

// File: act_tanh.sv
`timescale 1ns/1ps

module act_tanh
(
  input  logic [lstm_pkg::DATA_WIDTH-1:0] x,
  output logic [lstm_pkg::DATA_WIDTH-1:0] tanh_out
);

  localparam int DW = lstm_pkg::DATA_WIDTH;
  localparam int FB = lstm_pkg::FRAC_BITS;
  localparam int NUM_EDGES = 9;  // 0.1 steps inside one integer unit
  localparam int LAST_BIN = 21;
  localparam logic [DW-1:0] SAT_LIMIT = 16'h3000;  // 3.0

  logic [DW-1:0] mag;
  logic [DW-1:0] lut;
  logic [3:0]    frac_bin;
  logic [4:0]    address;
  int            bin_idx;

  // fraction thresholds for .1 .. .9
  function automatic logic [FB-1:0] step_edge(input int k);
    case (k)
      0:       step_edge = 12'h19a;
      1:       step_edge = 12'h333;
      2:       step_edge = 12'h4cd;
      3:       step_edge = 12'h666;
      4:       step_edge = 12'h800;
      5:       step_edge = 12'h99a;
      6:       step_edge = 12'hb33;
      7:       step_edge = 12'hccd;
      default: step_edge = 12'he66;
    endcase
  endfunction

  assign mag = x[DW-1] ? (~x + 16'd1) : x;  // 0x8000 stays 0x8000, lands in saturation

  always_comb
  begin
    frac_bin = '0;
    for (int k = 0; k < NUM_EDGES; k++)
    begin
      if (mag[FB-1:0] >= step_edge(k))
        frac_bin = frac_bin + 4'd1;
    end
  end

  // bin 0 starts at 0.5, ten bins per unit, everything from 2.6 shares the last one
  always_comb
  begin
    bin_idx = 10 * int'(mag[FB+1:FB]) + int'(frac_bin) - 5;
    if (mag < lstm_pkg::FX_HALF)
      address = 5'd23;  // small input, tanh(x) ~ x
    else if (mag >= SAT_LIMIT)
      address = 5'd22;
    else if (bin_idx > LAST_BIN)
      address = 5'(LAST_BIN);
    else
      address = 5'(bin_idx);
  end

  always_comb
  begin
    case (address)
      5'd0:    lut = 16'h0802;  // 0.55
      5'd1:    lut = 16'h0925;
      5'd2:    lut = 16'h0a29;
      5'd3:    lut = 16'h0b0e;
      5'd4:    lut = 16'h0bd6;
      5'd5:    lut = 16'h0c82;  // 1.05
      5'd6:    lut = 16'h0d15;
      5'd7:    lut = 16'h0d92;
      5'd8:    lut = 16'h0dfc;
      5'd9:    lut = 16'h0e54;
      5'd10:   lut = 16'h0e9e;
      5'd11:   lut = 16'h0edc;
      5'd12:   lut = 16'h0f0f;
      5'd13:   lut = 16'h0f3a;
      5'd14:   lut = 16'h0f5d;
      5'd15:   lut = 16'h0f7a;  // 2.05
      5'd16:   lut = 16'h0f92;
      5'd17:   lut = 16'h0fa6;
      5'd18:   lut = 16'h0fb6;
      5'd19:   lut = 16'h0fc3;
      5'd20:   lut = 16'h0fce;
      5'd21:   lut = 16'h0feb;  // 3.0, covers 2.6 up to the limit
      5'd22:   lut = lstm_pkg::FX_ONE;
      5'd23:   lut = mag;
      default: lut = '0;
    endcase
  end

  assign tanh_out = x[DW-1] ? (~lut + 16'd1) : lut;  // odd function, restore sign

endmodule

// File: lstm_pkg.sv
package lstm_pkg;

  // fixed-point format, Q4.12
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 12;

  localparam logic [DATA_WIDTH-1:0] FX_ONE  = 16'h1000;  // 1.0
  localparam logic [DATA_WIDTH-1:0] FX_HALF = 16'h0800;  // 0.5

  // AXI4-Lite register bus
  localparam int AXI_ADDR_WIDTH = 4;
  localparam int AXI_DATA_WIDTH = 32;

  localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL       = 4'h0;  // bit0 enable, bit1 clear
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS     = 4'h4;  // finished element count
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATE_SEL  = 4'h8;  // neuron index for readback
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATE_DATA = 4'hC;  // selected cell state, read only

  localparam int DEFAULT_ARRAY_DEPTH = 64;  // hidden neurons

endpackage
